// File: common/rv_pkg.sv
// Core widths, opcode / ALU / redirect enums
// and the encoded no-op instruction
`default_nettype none

package rv_pkg;

  parameter int xlen       = 32; // Data and address width
  parameter int reg_addr_w = 5;
  parameter int inst_w     = 32;

  // Major opcodes handled by the core
  typedef enum logic [6:0] {
    op_reg    = 7'b0110011,
    op_imm    = 7'b0010011,
    op_lui    = 7'b0110111,
    op_auipc  = 7'b0010111,
    op_branch = 7'b1100011,
    op_jal    = 7'b1101111,
    op_jalr   = 7'b1100111,
    op_system = 7'b1110011 // ECALL/EBREAK have no effect here
  } opcode_t;

  // Alternate bit (inst[30]) on top of funct3
  typedef enum logic [3:0] {
    alu_add  = 4'b0000,
    alu_sub  = 4'b1000,
    alu_sll  = 4'b0001,
    alu_slt  = 4'b0010,
    alu_sltu = 4'b0011,
    alu_xor  = 4'b0100,
    alu_srl  = 4'b0101,
    alu_sra  = 4'b1101,
    alu_or   = 4'b0110,
    alu_and  = 4'b0111
  } alu_op_t;

  // How a lane may change the program counter
  typedef enum logic [1:0] {
    br_none = 2'b00,
    br_cond = 2'b01, // Taken only if the comparator agrees
    br_jump = 2'b10
  } branch_kind_t;

  parameter logic [inst_w-1:0] nop_inst = 32'h0000_0013; // addi x0, x0, 0

endpackage

`default_nettype wire

// File: design/commit_unit.sv
// Program counter, write-back data selection and next-PC choice
`default_nettype none

module commit_unit
  import rv_pkg::*;
#(
  parameter logic [xlen-1:0] reset_pc = 32'd0
) (
  input  wire                   clock,
  input  wire                   reset_n,
  input  wire                   slot1_valid,
  input  wire                   lane0_rd_we,
  input  wire [reg_addr_w-1:0]  lane0_rd_addr,
  input  wire [xlen-1:0]        lane0_result,
  input  wire                   lane0_link,
  input  wire                   lane0_redirect,
  input  wire [xlen-1:0]        lane0_target,
  input  wire                   lane1_rd_we,
  input  wire [reg_addr_w-1:0]  lane1_rd_addr,
  input  wire [xlen-1:0]        lane1_result,
  input  wire                   lane1_link,
  input  wire                   lane1_redirect,
  input  wire [xlen-1:0]        lane1_target,
  output logic [xlen-1:0]       pc,
  output logic                  wr0_en,
  output logic [reg_addr_w-1:0] wr0_addr,
  output logic [xlen-1:0]       wr0_data,
  output logic                  wr1_en,
  output logic [reg_addr_w-1:0] wr1_addr,
  output logic [xlen-1:0]       wr1_data,
  output logic                  pair_issued
);

  logic [xlen-1:0] pc_plus4;
  logic [xlen-1:0] pc_plus8;
  logic [xlen-1:0] next_pc;

  assign pc_plus4 = pc + 32'd4;
  assign pc_plus8 = pc + 32'd8;

  // Link value is the address after the lane's own instruction
  assign wr0_en   = reset_n && lane0_rd_we;
  assign wr0_addr = lane0_rd_addr;
  assign wr0_data = lane0_link ? pc_plus4 : lane0_result;
  assign wr1_en   = reset_n && lane1_rd_we;
  assign wr1_addr = lane1_rd_addr;
  assign wr1_data = lane1_link ? pc_plus8 : lane1_result;

  assign pair_issued = slot1_valid;

  assign next_pc = slot1_valid ? (lane1_redirect ? lane1_target : pc_plus8) :
                                 (lane0_redirect ? lane0_target : pc_plus4);

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      pc <= reset_pc;
    end else begin
      pc <= next_pc;
    end
  end

endmodule

`default_nettype wire

// File: design/dual_issue_core.sv
// Dual-issue RV32I core top: issue check, two lanes,
// register file and commit unit
`default_nettype none

module dual_issue_core
  import rv_pkg::*;
#(
  parameter logic [xlen-1:0] reset_pc = 32'd0
) (
  input  wire                   clock,
  input  wire                   reset_n,
  output logic [xlen-1:0]       fetch_addr,
  input  wire [2*inst_w-1:0]    fetch_pair,
  output logic                  wr0_en,
  output logic [reg_addr_w-1:0] wr0_addr,
  output logic [xlen-1:0]       wr0_data,
  output logic                  wr1_en,
  output logic [reg_addr_w-1:0] wr1_addr,
  output logic [xlen-1:0]       wr1_data,
  output logic                  pair_issued
);

  logic                  slot1_valid;
  logic [reg_addr_w-1:0] l0_rs1_addr, l0_rs2_addr, l1_rs1_addr, l1_rs2_addr;
  logic [xlen-1:0]       l0_rs1_data, l0_rs2_data, l1_rs1_data, l1_rs2_data;
  logic                  l0_rd_we, l1_rd_we;
  logic [reg_addr_w-1:0] l0_rd_addr, l1_rd_addr;
  logic [xlen-1:0]       l0_result, l1_result;
  logic                  l0_redirect, l1_redirect;
  logic [xlen-1:0]       l0_target, l1_target;
  logic                  l0_link, l1_link;

  pair_issue u_pair_issue (
    .fetch_pair  (fetch_pair),
    .slot1_valid (slot1_valid)
  );

  lane_exec #(.pc_offset(32'd0)) lane0 (
    .inst     (fetch_pair[inst_w-1:0]),
    .issue    (1'b1), // Slot 0 always executes
    .pc       (fetch_addr),
    .rs1_addr (l0_rs1_addr),
    .rs2_addr (l0_rs2_addr),
    .rs1_data (l0_rs1_data),
    .rs2_data (l0_rs2_data),
    .rd_we    (l0_rd_we),
    .rd_addr  (l0_rd_addr),
    .result   (l0_result),
    .redirect (l0_redirect),
    .target   (l0_target),
    .link     (l0_link)
  );

  lane_exec #(.pc_offset(32'd4)) lane1 (
    .inst     (fetch_pair[2*inst_w-1:inst_w]),
    .issue    (slot1_valid),
    .pc       (fetch_addr),
    .rs1_addr (l1_rs1_addr),
    .rs2_addr (l1_rs2_addr),
    .rs1_data (l1_rs1_data),
    .rs2_data (l1_rs2_data),
    .rd_we    (l1_rd_we),
    .rd_addr  (l1_rd_addr),
    .result   (l1_result),
    .redirect (l1_redirect),
    .target   (l1_target),
    .link     (l1_link)
  );

  reg_file u_reg_file (
    .clock   (clock),
    .reset_n (reset_n),
    .raddr0  (l0_rs1_addr),
    .rdata0  (l0_rs1_data),
    .raddr1  (l0_rs2_addr),
    .rdata1  (l0_rs2_data),
    .raddr2  (l1_rs1_addr),
    .rdata2  (l1_rs1_data),
    .raddr3  (l1_rs2_addr),
    .rdata3  (l1_rs2_data),
    .we0     (wr0_en),
    .waddr0  (wr0_addr),
    .wdata0  (wr0_data),
    .we1     (wr1_en),
    .waddr1  (wr1_addr),
    .wdata1  (wr1_data)
  );

  commit_unit #(.reset_pc(reset_pc)) u_commit (
    .clock          (clock),
    .reset_n        (reset_n),
    .slot1_valid    (slot1_valid),
    .lane0_rd_we    (l0_rd_we),
    .lane0_rd_addr  (l0_rd_addr),
    .lane0_result   (l0_result),
    .lane0_link     (l0_link),
    .lane0_redirect (l0_redirect),
    .lane0_target   (l0_target),
    .lane1_rd_we    (l1_rd_we),
    .lane1_rd_addr  (l1_rd_addr),
    .lane1_result   (l1_result),
    .lane1_link     (l1_link),
    .lane1_redirect (l1_redirect),
    .lane1_target   (l1_target),
    .pc             (fetch_addr), // Fetch address is the live pc
    .wr0_en         (wr0_en),
    .wr0_addr       (wr0_addr),
    .wr0_data       (wr0_data),
    .wr1_en         (wr1_en),
    .wr1_addr       (wr1_addr),
    .wr1_data       (wr1_data),
    .pair_issued    (pair_issued)
  );

endmodule

`default_nettype wire

// File: design/pair_issue.sv
// Pair hazard check for the fetched instruction pair
`default_nettype none

module pair_issue
  import rv_pkg::*;
(
  input  wire [2*inst_w-1:0] fetch_pair,
  output logic               slot1_valid
);

  logic [inst_w-1:0]     inst0;
  logic [inst_w-1:0]     inst1;
  opcode_t               op0;
  opcode_t               op1;
  logic [reg_addr_w-1:0] rd0;
  logic [reg_addr_w-1:0] rs1_1;
  logic [reg_addr_w-1:0] rs2_1;
  logic                  ctrl0;
  logic                  writes0;
  logic                  reads_rs1;
  logic                  reads_rs2;
  logic                  raw_hit;

  assign inst0 = fetch_pair[inst_w-1:0];
  assign inst1 = fetch_pair[2*inst_w-1:inst_w]; // Later instruction in the high word
  assign op0   = opcode_t'(inst0[6:0]);
  assign op1   = opcode_t'(inst1[6:0]);
  assign rd0   = inst0[11:7];
  assign rs1_1 = inst1[19:15];
  assign rs2_1 = inst1[24:20];

  // Slot 0 ending the pair
  assign ctrl0 = op0 inside {op_branch, op_jal, op_jalr, op_system};

  assign writes0 = (rd0 != '0) &&
                   (op0 inside {op_reg, op_imm, op_lui, op_auipc, op_jal, op_jalr});

  // Only the sources slot 1 really uses for its format
  assign reads_rs1 = (rs1_1 != '0) && (op1 inside {op_reg, op_imm, op_branch, op_jalr});
  assign reads_rs2 = (rs2_1 != '0) && (op1 inside {op_reg, op_branch});

  assign raw_hit = writes0 &&
                   ((reads_rs1 && (rs1_1 == rd0)) || (reads_rs2 && (rs2_1 == rd0)));

  assign slot1_valid = !ctrl0 && !raw_hit;

endmodule

`default_nettype wire

// File: design/reg_file.sv
// General register file, four read and two write ports
`default_nettype none

module reg_file
  import rv_pkg::*;
(
  input  wire                   clock,
  input  wire                   reset_n,
  input  wire [reg_addr_w-1:0]  raddr0,
  output logic [xlen-1:0]       rdata0,
  input  wire [reg_addr_w-1:0]  raddr1,
  output logic [xlen-1:0]       rdata1,
  input  wire [reg_addr_w-1:0]  raddr2,
  output logic [xlen-1:0]       rdata2,
  input  wire [reg_addr_w-1:0]  raddr3,
  output logic [xlen-1:0]       rdata3,
  input  wire                   we0,
  input  wire [reg_addr_w-1:0]  waddr0,
  input  wire [xlen-1:0]        wdata0,
  input  wire                   we1,
  input  wire [reg_addr_w-1:0]  waddr1,
  input  wire [xlen-1:0]        wdata1
);

  logic [xlen-1:0] regs [1:31]; // No storage for x0

  assign rdata0 = (raddr0 == '0) ? '0 : regs[raddr0];
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];
  assign rdata3 = (raddr3 == '0) ? '0 : regs[raddr3];

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (we0 && (waddr0 != '0)) begin
        regs[waddr0] <= wdata0;
      end
      if (we1 && (waddr1 != '0)) begin
        regs[waddr1] <= wdata1; // Later lane wins a clash
      end
    end
  end

endmodule

`default_nettype wire

// File: lane/lane_alu.sv
// Integer ALU and branch comparator of one lane
`default_nettype none

module lane_alu
  import rv_pkg::*;
(
  input  wire alu_op_t      alu_op,
  input  wire [xlen-1:0]    op_a,
  input  wire [xlen-1:0]    op_b,
  input  wire [2:0]         funct3,
  input  wire [xlen-1:0]    rs1_data,
  input  wire [xlen-1:0]    rs2_data,
  output logic [xlen-1:0]   result,
  output logic              cond_true
);

  logic [4:0] shamt;

  assign shamt = op_b[4:0]; // Upper bits ignored

  always_comb begin
    case (alu_op)
      alu_add:  result = op_a + op_b;
      alu_sub:  result = op_a - op_b;
      alu_sll:  result = op_a << shamt;
      alu_slt:  result = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      alu_sltu: result = {{(xlen-1){1'b0}}, op_a < op_b};
      alu_xor:  result = op_a ^ op_b;
      alu_srl:  result = op_a >> shamt;
      alu_sra:  result = $unsigned($signed(op_a) >>> shamt);
      alu_or:   result = op_a | op_b;
      alu_and:  result = op_a & op_b;
      default:  result = '0;
    endcase
  end

  // Compares the register operands, not the ALU inputs
  always_comb begin
    case (funct3)
      3'b000:  cond_true = (rs1_data == rs2_data); // BEQ
      3'b001:  cond_true = (rs1_data != rs2_data); // BNE
      3'b100:  cond_true = ($signed(rs1_data) < $signed(rs2_data)); // BLT
      3'b101:  cond_true = ($signed(rs1_data) >= $signed(rs2_data)); // BGE
      3'b110:  cond_true = (rs1_data < rs2_data); // BLTU
      3'b111:  cond_true = (rs1_data >= rs2_data); // BGEU
      default: cond_true = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// File: lane/lane_decode.sv
// Lane instruction decode: register fields, immediates,
// ALU operation, operand selects and write/redirect controls
`default_nettype none

module lane_decode
  import rv_pkg::*;
(
  input  wire [inst_w-1:0]      inst,
  output logic [reg_addr_w-1:0] rs1_addr,
  output logic [reg_addr_w-1:0] rs2_addr,
  output logic [reg_addr_w-1:0] rd_addr,
  output logic [xlen-1:0]       imm,
  output alu_op_t               alu_op,
  output logic                  op_a_pc,
  output logic                  op_b_imm,
  output logic                  rd_we,
  output branch_kind_t          branch_kind,
  output logic [2:0]            funct3
);

  opcode_t         op;
  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_b;
  logic [xlen-1:0] imm_u;
  logic [xlen-1:0] imm_j;
  logic            legal;

  assign op       = opcode_t'(inst[6:0]);
  assign funct3   = inst[14:12];
  assign rd_addr  = inst[11:7];
  assign rs1_addr = (op == op_lui) ? '0 : inst[19:15]; // LUI adds to zero
  assign rs2_addr = inst[24:20];

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    imm         = imm_i;
    alu_op      = alu_add;
    op_a_pc     = 1'b0;
    op_b_imm    = 1'b1;
    branch_kind = br_none;
    legal       = 1'b0;
    case (op)
      op_reg: begin
        alu_op   = alu_op_t'({inst[30], funct3});
        op_b_imm = 1'b0;
        // inst[30] is only meaningful for SUB and SRA
        legal    = ({inst[31], inst[29:25]} == 6'b0) &&
                   (!inst[30] || (funct3 == 3'b000) || (funct3 == 3'b101));
      end
      op_imm: begin
        if (funct3 == 3'b101) begin
          alu_op = alu_op_t'({inst[30], funct3}); // SRLI or SRAI
          legal  = ({inst[31], inst[29:25]} == 6'b0);
        end else begin
          alu_op = alu_op_t'({1'b0, funct3});
          legal  = (funct3 != 3'b001) || (inst[31:25] == 7'b0);
        end
      end
      op_lui: begin
        imm   = imm_u;
        legal = 1'b1;
      end
      op_auipc: begin
        imm     = imm_u;
        op_a_pc = 1'b1;
        legal   = 1'b1;
      end
      op_branch: begin
        imm         = imm_b;
        op_a_pc     = 1'b1; // ALU forms the target
        branch_kind = br_cond;
      end
      op_jal: begin
        imm         = imm_j;
        op_a_pc     = 1'b1;
        branch_kind = br_jump;
        legal       = 1'b1;
      end
      op_jalr: begin
        branch_kind = br_jump; // rs1 + imm_i
        legal       = 1'b1;
      end
      default: begin
        legal = 1'b0; // System, FENCE and unknown fall through
      end
    endcase
  end

  assign rd_we = legal && (rd_addr != '0);

endmodule

`default_nettype wire

// File: lane/lane_exec.sv
// Execution lane: decode, operand selection, ALU and redirect
`default_nettype none

module lane_exec
  import rv_pkg::*;
#(
  parameter logic [xlen-1:0] pc_offset = 32'd0
) (
  input  wire [inst_w-1:0]      inst,
  input  wire                   issue,
  input  wire [xlen-1:0]        pc,
  output logic [reg_addr_w-1:0] rs1_addr,
  output logic [reg_addr_w-1:0] rs2_addr,
  input  wire [xlen-1:0]        rs1_data,
  input  wire [xlen-1:0]        rs2_data,
  output logic                  rd_we,
  output logic [reg_addr_w-1:0] rd_addr,
  output logic [xlen-1:0]       result,
  output logic                  redirect,
  output logic [xlen-1:0]       target,
  output logic                  link
);

  logic [inst_w-1:0] inst_eff;
  logic [xlen-1:0]   inst_addr;
  logic [xlen-1:0]   imm;
  alu_op_t           alu_op;
  logic              op_a_pc;
  logic              op_b_imm;
  branch_kind_t      branch_kind;
  logic [2:0]        funct3;
  logic [xlen-1:0]   op_a;
  logic [xlen-1:0]   op_b;
  logic              cond_true;

  assign inst_eff  = issue ? inst : nop_inst; // Unissued slot does nothing
  assign inst_addr = pc + pc_offset;

  lane_decode u_decode (
    .inst        (inst_eff),
    .rs1_addr    (rs1_addr),
    .rs2_addr    (rs2_addr),
    .rd_addr     (rd_addr),
    .imm         (imm),
    .alu_op      (alu_op),
    .op_a_pc     (op_a_pc),
    .op_b_imm    (op_b_imm),
    .rd_we       (rd_we),
    .branch_kind (branch_kind),
    .funct3      (funct3)
  );

  assign op_a = op_a_pc ? inst_addr : rs1_data;
  assign op_b = op_b_imm ? imm : rs2_data;

  lane_alu u_alu (
    .alu_op    (alu_op),
    .op_a      (op_a),
    .op_b      (op_b),
    .funct3    (funct3),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .result    (result),
    .cond_true (cond_true)
  );

  assign redirect = (branch_kind == br_jump) || ((branch_kind == br_cond) && cond_true);
  assign target   = {result[xlen-1:1], 1'b0}; // JALR needs bit 0 cleared
  assign link     = (branch_kind == br_jump);

endmodule

`default_nettype wire

// File: test/tb_dual_issue_core.sv
// Dual-issue core testbench with program ROM model,
// shadow reference model and directed tests
`default_nettype none

module tb_dual_issue_core;

  localparam logic [6:0] opc_reg    = 7'b0110011;
  localparam logic [6:0] opc_imm    = 7'b0010011;
  localparam logic [6:0] opc_lui    = 7'b0110111;
  localparam logic [6:0] opc_auipc  = 7'b0010111;
  localparam logic [6:0] opc_branch = 7'b1100011;
  localparam logic [6:0] opc_jal    = 7'b1101111;
  localparam logic [6:0] opc_jalr   = 7'b1100111;
  localparam logic [6:0] opc_system = 7'b1110011;
  localparam int cycle_limit = 400; // All tests take about 110 cycles

  logic        clock;
  logic        reset_n;
  logic [31:0] fetch_addr;
  logic [63:0] fetch_pair;
  logic        wr0_en;
  logic [4:0]  wr0_addr;
  logic [31:0] wr0_data;
  logic        wr1_en;
  logic [4:0]  wr1_addr;
  logic [31:0] wr1_data;
  logic        pair_issued;

  logic [31:0] prog [0:63]; // ROM seen by the DUT
  logic [31:0] img [0:63];  // Next program, built by a test
  logic [31:0] ref_regs [0:31];
  logic [31:0] ref_pc;
  logic [5:0]  fetch_idx;
  integer      seed = 32'h25f5_99cc;
  int          check_count = 0;
  int          error_count = 0;
  int          cycle_count = 0;

  dual_issue_core #(.reset_pc(32'd0)) uut (
    .clock       (clock),
    .reset_n     (reset_n),
    .fetch_addr  (fetch_addr),
    .fetch_pair  (fetch_pair),
    .wr0_en      (wr0_en),
    .wr0_addr    (wr0_addr),
    .wr0_data    (wr0_data),
    .wr1_en      (wr1_en),
    .wr1_addr    (wr1_addr),
    .wr1_data    (wr1_data),
    .pair_issued (pair_issued)
  );

  assign fetch_idx  = fetch_addr[7:2];
  assign fetch_pair = {prog[fetch_idx + 6'd1], prog[fetch_idx]}; // Wraps at 256 bytes

  always #4 clock = ~clock;

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Error: run did not end within %0d cycles, %0d errors so far",
               cycle_limit, error_count);
      $display("Simulation failed");
      $finish;
    end
  end

  function automatic logic [31:0] encode_reg(input logic [6:0] funct7, input logic [2:0] funct3,
                                             input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [4:0] rs2);
    return {funct7, rs2, rs1, funct3, rd, opc_reg};
  endfunction

  function automatic logic [31:0] encode_imm(input logic [6:0] opcode, input logic [2:0] funct3,
                                             input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [11:0] imm);
    return {imm, rs1, funct3, rd, opcode};
  endfunction

  function automatic logic [31:0] encode_upper(input logic [6:0] opcode, input logic [4:0] rd,
                                               input logic [19:0] imm);
    return {imm, rd, opcode};
  endfunction

  function automatic logic [31:0] encode_branch(input logic [2:0] funct3, input logic [4:0] rs1,
                                                input logic [4:0] rs2, input logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, funct3, imm[4:1], imm[11], opc_branch};
  endfunction

  function automatic logic [31:0] encode_jal(input logic [4:0] rd, input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc_jal};
  endfunction

  function automatic logic [11:0] random_imm();
    logic [31:0] rnd;
    rnd = $random(seed);
    return rnd[11:0];
  endfunction

  function automatic logic [19:0] random_upper();
    logic [31:0] rnd;
    rnd = $random(seed);
    return rnd[31:12];
  endfunction

  // Fill word addi x0, x0, index writes nothing and differs per word
  function automatic logic [31:0] fill_word(input int index);
    return encode_imm(opc_imm, 3'd0, 5'd0, 5'd0, {6'd0, index[5:0]});
  endfunction

  function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] x, input logic [31:0] y);
    logic [31:0] r;
    case (f3)
      3'd0: r = alt ? x - y : x + y;
      3'd1: r = x << y[4:0];
      3'd2: r = {31'd0, $signed(x) < $signed(y)};
      3'd3: r = {31'd0, x < y};
      3'd4: r = x ^ y;
      3'd5: begin
        if (alt) begin
          r = $signed(x) >>> y[4:0];
        end else begin
          r = x >> y[4:0];
        end
      end
      3'd6: r = x | y;
      default: r = x & y;
    endcase
    return r;
  endfunction

  function automatic logic branch_model(input logic [2:0] f3, input logic [31:0] x,
                                        input logic [31:0] y);
    case (f3)
      3'd0: return x == y;
      3'd1: return x != y;
      3'd4: return $signed(x) < $signed(y);
      3'd5: return $signed(x) >= $signed(y);
      3'd6: return x < y;
      3'd7: return x >= y;
      default: return 1'b0;
    endcase
  endfunction

  // RV32I meaning of one instruction against the shadow registers
  task automatic model_inst(input logic [31:0] inst, input logic [31:0] addr,
                            output logic we, output logic [4:0] rd,
                            output logic [31:0] val, output logic redir,
                            output logic [31:0] tgt);
    logic [31:0] src1, src2, imm_i, imm_b, imm_u, imm_j;
    logic [2:0]  f3;
    src1  = ref_regs[inst[19:15]];
    src2  = ref_regs[inst[24:20]];
    f3    = inst[14:12];
    rd    = inst[11:7];
    imm_i = {{20{inst[31]}}, inst[31:20]};
    imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    imm_u = {inst[31:12], 12'd0};
    imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    we    = 1'b0;
    val   = 32'd0;
    redir = 1'b0;
    tgt   = 32'd0;
    case (inst[6:0])
      opc_reg: begin
        we  = 1'b1;
        val = alu_model(f3, inst[30], src1, src2);
      end
      opc_imm: begin
        we  = 1'b1;
        val = alu_model(f3, inst[30] && (f3 == 3'd5), src1, imm_i); // Only SRAI uses bit 30
      end
      opc_lui: begin
        we  = 1'b1;
        val = imm_u;
      end
      opc_auipc: begin
        we  = 1'b1;
        val = addr + imm_u;
      end
      opc_branch: begin
        redir = branch_model(f3, src1, src2);
        tgt   = addr + imm_b;
      end
      opc_jal: begin
        we    = 1'b1;
        val   = addr + 32'd4;
        redir = 1'b1;
        tgt   = addr + imm_j;
      end
      opc_jalr: begin
        we    = 1'b1;
        val   = addr + 32'd4;
        redir = 1'b1;
        tgt   = src1 + imm_i;
      end
      default: begin
        we = 1'b0; // System and others fall through
      end
    endcase
    tgt = tgt & ~32'd1;
    if (rd == 5'd0) begin
      we = 1'b0;
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    assert (actual === expected)
      else begin
        error_count++;
        $display("mismatch %s: expected %h, actual %h at %0t", name, expected, actual, $time);
      end
  endtask

  // Expected outputs of the current cycle, then the shadow state update
  task automatic compare_cycle();
    logic [5:0]  idx;
    logic [31:0] inst0, inst1, val0, val1, tgt0, tgt1;
    logic [4:0]  rd0, rd1;
    logic        we0, we1, redir0, redir1, ends_pair, uses_rs1, uses_rs2, issue;
    idx   = ref_pc[7:2];
    inst0 = prog[idx];
    inst1 = prog[idx + 6'd1];
    model_inst(inst0, ref_pc, we0, rd0, val0, redir0, tgt0);
    model_inst(inst1, ref_pc + 32'd4, we1, rd1, val1, redir1, tgt1);
    ends_pair = (inst0[6:0] == opc_branch) || (inst0[6:0] == opc_jal) ||
                (inst0[6:0] == opc_jalr) || (inst0[6:0] == opc_system);
    uses_rs1  = (inst1[6:0] == opc_reg) || (inst1[6:0] == opc_imm) ||
                (inst1[6:0] == opc_branch) || (inst1[6:0] == opc_jalr);
    uses_rs2  = (inst1[6:0] == opc_reg) || (inst1[6:0] == opc_branch);
    issue     = !ends_pair && !(we0 && ((uses_rs1 && (inst1[19:15] == rd0)) ||
                                        (uses_rs2 && (inst1[24:20] == rd0))));
    if (!issue) begin
      we1    = 1'b0;
      redir1 = 1'b0;
    end
    check_value("fetch_addr", ref_pc, fetch_addr);
    check_value("pair_issued", {31'd0, issue}, {31'd0, pair_issued});
    check_value("wr0_en", {31'd0, we0}, {31'd0, wr0_en});
    check_value("wr1_en", {31'd0, we1}, {31'd0, wr1_en});
    if (we0) begin
      check_value("wr0_addr", {27'd0, rd0}, {27'd0, wr0_addr});
      check_value("wr0_data", val0, wr0_data);
      ref_regs[rd0] = val0;
    end
    if (we1) begin
      check_value("wr1_addr", {27'd0, rd1}, {27'd0, wr1_addr});
      check_value("wr1_data", val1, wr1_data);
      ref_regs[rd1] = val1; // Later slot written last
    end
    if (issue) begin
      ref_pc = redir1 ? tgt1 : ref_pc + 32'd8;
    end else begin
      ref_pc = redir0 ? tgt0 : ref_pc + 32'd4;
    end
  endtask

  task automatic clear_image();
    for (int i = 0; i < 64; i++) begin
      img[i] = fill_word(i);
    end
  endtask

  // Loads the image under reset, then follows the core cycle by cycle
  task automatic run_program(input int cycles);
    @(posedge clock);
    reset_n <= 1'b0;
    for (int i = 0; i < 64; i++) begin
      prog[i] <= img[i];
    end
    repeat (5) begin
      @(negedge clock);
      check_value("fetch_addr", 32'd0, fetch_addr);
      check_value("wr0_en", 32'd0, {31'd0, wr0_en});
      check_value("wr1_en", 32'd0, {31'd0, wr1_en});
    end
    @(posedge clock);
    reset_n <= 1'b1;
    ref_pc = 32'd0;
    for (int i = 0; i < 32; i++) begin
      ref_regs[i] = 32'd0;
    end
    repeat (cycles) begin
      @(negedge clock);
      compare_cycle();
    end
  endtask

  task automatic test_reset();
    clear_image();
    run_program(6);
  endtask

  task automatic test_independent_pairs();
    logic [31:0] val_a, val_b;
    val_a = ($random(seed) | 32'h8000_0000) & 32'hffff_f7ff; // Negative x1
    val_b = $random(seed) & 32'h7fff_f7ff; // Positive x2
    clear_image();
    img[0]  = encode_upper(opc_lui, 5'd1, val_a[31:12]);
    img[1]  = encode_upper(opc_lui, 5'd2, val_b[31:12]);
    img[2]  = encode_imm(opc_imm, 3'd0, 5'd1, 5'd1, val_a[11:0]);
    img[3]  = encode_imm(opc_imm, 3'd0, 5'd2, 5'd2, val_b[11:0]);
    img[4]  = encode_reg(7'h00, 3'd0, 5'd3, 5'd1, 5'd2); // add
    img[5]  = encode_reg(7'h20, 3'd0, 5'd4, 5'd1, 5'd2); // sub
    img[6]  = encode_reg(7'h00, 3'd1, 5'd5, 5'd1, 5'd2);
    img[7]  = encode_reg(7'h20, 3'd5, 5'd6, 5'd1, 5'd2); // sra
    img[8]  = encode_reg(7'h00, 3'd2, 5'd7, 5'd1, 5'd2);
    img[9]  = encode_reg(7'h00, 3'd3, 5'd8, 5'd1, 5'd2);
    img[10] = encode_reg(7'h00, 3'd4, 5'd9, 5'd1, 5'd2);
    img[11] = encode_reg(7'h00, 3'd6, 5'd10, 5'd1, 5'd2);
    img[12] = encode_reg(7'h00, 3'd7, 5'd11, 5'd1, 5'd2);
    img[13] = encode_reg(7'h00, 3'd5, 5'd12, 5'd2, 5'd1); // srl
    img[14] = encode_imm(opc_imm, 3'd0, 5'd13, 5'd1, random_imm());
    img[15] = encode_imm(opc_imm, 3'd5, 5'd14, 5'd1, 12'h400 | (random_imm() & 12'h01f));
    img[16] = encode_imm(opc_imm, 3'd2, 5'd15, 5'd1, random_imm());
    img[17] = encode_imm(opc_imm, 3'd3, 5'd16, 5'd2, random_imm());
    img[18] = encode_imm(opc_imm, 3'd4, 5'd17, 5'd1, random_imm());
    img[19] = encode_imm(opc_imm, 3'd6, 5'd18, 5'd2, random_imm());
    img[20] = encode_imm(opc_imm, 3'd7, 5'd19, 5'd1, random_imm());
    img[21] = encode_imm(opc_imm, 3'd1, 5'd20, 5'd2, random_imm() & 12'h01f);
    img[22] = encode_imm(opc_imm, 3'd5, 5'd21, 5'd1, random_imm() & 12'h01f);
    img[23] = encode_imm(opc_imm, 3'd0, 5'd22, 5'd2, random_imm());
    run_program(14);
  endtask

  task automatic test_dependent_pairs();
    clear_image();
    img[0]  = encode_imm(opc_imm, 3'd0, 5'd1, 5'd0, random_imm());
    img[1]  = encode_imm(opc_imm, 3'd0, 5'd2, 5'd1, 12'd5); // Reads x1 just written
    img[2]  = encode_reg(7'h00, 3'd0, 5'd3, 5'd2, 5'd1);
    img[3]  = encode_imm(opc_imm, 3'd0, 5'd0, 5'd1, 12'd9); // Write to x0
    img[4]  = encode_reg(7'h00, 3'd0, 5'd4, 5'd0, 5'd1);
    img[5]  = encode_reg(7'h20, 3'd0, 5'd5, 5'd1, 5'd2);
    img[6]  = encode_imm(opc_imm, 3'd0, 5'd0, 5'd3, 12'd1);
    img[7]  = encode_reg(7'h00, 3'd0, 5'd6, 5'd0, 5'd0);
    img[8]  = encode_upper(opc_lui, 5'd7, random_upper());
    img[9]  = encode_reg(7'h00, 3'd3, 5'd8, 5'd0, 5'd7); // rs2 hazard
    img[10] = encode_reg(7'h00, 3'd4, 5'd9, 5'd8, 5'd7);
    run_program(12);
  endtask

  task automatic test_branches();
    clear_image();
    img[0]  = encode_imm(opc_imm, 3'd0, 5'd1, 5'd0, 12'hffb); // x1 = -5
    img[1]  = encode_imm(opc_imm, 3'd0, 5'd2, 5'd0, 12'd3);
    img[2]  = encode_imm(opc_imm, 3'd0, 5'd3, 5'd0, 12'd3);
    img[3]  = encode_imm(opc_imm, 3'd0, 5'd4, 5'd0, random_imm());
    img[4]  = encode_branch(3'd0, 5'd2, 5'd3, 13'd8); // beq taken
    img[5]  = encode_imm(opc_imm, 3'd0, 5'd10, 5'd0, 12'd1);
    img[6]  = encode_branch(3'd1, 5'd2, 5'd3, 13'd8);
    img[7]  = encode_branch(3'd4, 5'd1, 5'd2, 13'd8); // blt, signed
    img[8]  = encode_imm(opc_imm, 3'd0, 5'd10, 5'd0, 12'd2);
    img[9]  = encode_branch(3'd6, 5'd1, 5'd2, 13'd8); // bltu, unsigned
    img[10] = encode_branch(3'd5, 5'd1, 5'd2, 13'd8);
    img[11] = encode_branch(3'd7, 5'd1, 5'd2, 13'd8);
    img[12] = encode_imm(opc_imm, 3'd0, 5'd10, 5'd0, 12'd3);
    img[13] = encode_branch(3'd5, 5'd4, 5'd0, 13'd8);
    img[14] = encode_imm(opc_imm, 3'd0, 5'd11, 5'd0, 12'd4);
    img[15] = encode_branch(3'd6, 5'd4, 5'd1, 13'd8);
    img[16] = encode_imm(opc_imm, 3'd0, 5'd12, 5'd0, 12'd5);
    img[17] = encode_imm(opc_imm, 3'd0, 5'd13, 5'd0, 12'd6);
    run_program(16);
  endtask

  task automatic test_jumps();
    clear_image();
    img[0]  = encode_imm(opc_imm, 3'd0, 5'd2, 5'd0, 12'd41);
    img[1]  = encode_jal(5'd1, 21'd12); // Slot 1 of an issued pair
    img[4]  = encode_jal(5'd3, 21'd8);
    img[5]  = encode_imm(opc_imm, 3'd0, 5'd9, 5'd0, 12'd1);
    img[6]  = encode_imm(opc_jalr, 3'd0, 5'd4, 5'd2, 12'd8); // Odd sum 49
    img[7]  = encode_imm(opc_imm, 3'd0, 5'd9, 5'd0, 12'd2);
    img[12] = encode_imm(opc_imm, 3'd0, 5'd6, 5'd3, 12'd1);
    img[13] = encode_reg(7'h00, 3'd0, 5'd7, 5'd1, 5'd4);
    run_program(8);
  endtask

  task automatic test_upper_imm();
    clear_image();
    img[0] = encode_upper(opc_lui, 5'd1, random_upper());
    img[1] = encode_upper(opc_auipc, 5'd2, random_upper());
    img[2] = encode_upper(opc_auipc, 5'd3, random_upper());
    img[3] = encode_upper(opc_lui, 5'd4, random_upper());
    img[4] = encode_reg(7'h00, 3'd0, 5'd5, 5'd1, 5'd2);
    img[5] = encode_reg(7'h00, 3'd0, 5'd6, 5'd3, 5'd4);
    run_program(6);
  endtask

  initial begin
    clock   = 1'b0;
    reset_n = 1'b0;
    for (int i = 0; i < 64; i++) begin
      prog[i] = fill_word(i);
    end
    test_reset();
    test_independent_pairs();
    test_dependent_pairs();
    test_branches();
    test_jumps();
    test_upper_imm();
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
common/rv_pkg.sv
design/pair_issue.sv
lane/lane_decode.sv
lane/lane_alu.sv
lane/lane_exec.sv
design/reg_file.sv
design/commit_unit.sv
design/dual_issue_core.sv
test/tb_dual_issue_core.sv
